//--- include/gpio_defs.svh
`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// APB bus widths.
`define GPIO_DATA_WIDTH 32
`define GPIO_ADDR_WIDTH 12

// Number of pads handled by the peripheral.
`define GPIO_PINS 16

// Register map, byte offsets.
`define GPIO_IDR    12'h000
`define GPIO_ODR    12'h004
`define GPIO_MODER  12'h008
`define GPIO_OTYPER 12'h00C
// Two select bits per pin, pin i at bits 2i+1:2i.
`define GPIO_FSR0   12'h010
`define GPIO_FSR1   12'h014
`define GPIO_IER    12'h018

`endif

//--- project.f
+incdir+include
source/gpio_pkg.sv
source/gpio_apb_slave.sv
source/gpio_regs.sv
source/gpio_pad_ctrl.sv
source/gpio_top.sv
tb/gpio_tb.sv

//--- run.sh
#!/bin/sh
# Build the GPIO testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module gpio_tb -o gpio_sim &&
out=$(./obj_dir/gpio_sim) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qF '** PASS **' ||
{ echo "simulation did not pass"; exit 1; }

//--- source/gpio_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_slave (
    input  logic              seq,
    input  logic              arst_n,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  gpio_pkg::addr_t   paddr,
    input  gpio_pkg::data_t   pwdata,
    input  gpio_pkg::strb_t   pstrb,
    output gpio_pkg::data_t   prdata,
    output logic              pready,
    output logic              pslverr,

    output logic              reg_wr,
    output logic              reg_rd,
    output gpio_pkg::addr_t   reg_addr,
    output gpio_pkg::data_t   reg_wdata,
    output gpio_pkg::strb_t   reg_strb,
    input  gpio_pkg::data_t   reg_rdata,
    input  logic              reg_err
);

    gpio_pkg::apb_state_t phase;
    gpio_pkg::apb_state_t phase_q;
    logic                 xfer;

    // Phase seen on the bus in this cycle.
    always_comb begin
        if (!psel) begin
            phase = gpio_pkg::apb_idle;
        end else if (penable) begin
            phase = gpio_pkg::apb_access;
        end else begin
            phase = gpio_pkg::apb_setup;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= gpio_pkg::apb_idle;
        end else begin
            phase_q <= phase;
        end
    end

    // Only an access that directly follows its setup moves data.
    assign xfer = (phase == gpio_pkg::apb_access) && (phase_q == gpio_pkg::apb_setup);

    assign reg_wr    = xfer && pwrite;
    assign reg_rd    = xfer && !pwrite;
    assign reg_addr  = paddr;
    assign reg_wdata = pwdata;
    assign reg_strb  = pstrb;

    // No wait states, every access completes at once.
    assign pready  = (phase == gpio_pkg::apb_access);
    assign prdata  = reg_rdata;
    assign pslverr = xfer && reg_err;

    penable_needs_psel: assert property (
        @(posedge seq) disable iff (!arst_n) penable |-> psel
    );

    setup_then_access: assert property (
        @(posedge seq) disable iff (!arst_n) (psel && !penable) |=> (psel && penable)
    );

endmodule

`default_nettype wire

//--- source/gpio_pad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defs.svh"

module gpio_pad_ctrl (
    input  logic              seq,
    input  logic              arst_n,

    input  gpio_pkg::pin_t    pad_in,
    output gpio_pkg::pin_t    pad_out,
    output gpio_pkg::pin_t    pad_oe,

    input  gpio_pkg::pin_t    odr,
    input  gpio_pkg::pin_t    moder,
    input  gpio_pkg::pin_t    otyper,
    input  gpio_pkg::pin_t    ier,
    input  gpio_pkg::func_t   func,
    output gpio_pkg::pin_t    idr,

    input  gpio_pkg::pin_t    alt_out,
    input  gpio_pkg::pin_t    alt_oe,
    output logic              irq
);

    gpio_pkg::pin_t pad_meta;

    // Two flop synchronizer on the pad inputs.
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            pad_meta <= '0;
            idr      <= '0;
        end else begin
            pad_meta <= pad_in;
            idr      <= pad_meta;
        end
    end

    always_comb begin
        for (int i = 0; i < `GPIO_PINS; i++) begin
            if (func[2*i +: 2] != 2'b00) begin
                // Pad handed to an alternate function.
                pad_out[i] = alt_out[i];
                pad_oe[i]  = alt_oe[i];
            end else begin
                pad_out[i] = odr[i];
                // Open drain only drives the low level.
                pad_oe[i]  = moder[i] && (!otyper[i] || !odr[i]);
            end
        end
    end

    // Level interrupt.
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |(ier & idr);
        end
    end

endmodule

`default_nettype wire

//--- source/gpio_pkg.sv
`default_nettype none

`include "gpio_defs.svh"

package gpio_pkg;

    // Bus side.
    typedef logic [`GPIO_DATA_WIDTH-1:0]   data_t;
    typedef logic [`GPIO_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`GPIO_DATA_WIDTH/8-1:0] strb_t;

    // One bit per pin.
    typedef logic [`GPIO_PINS-1:0] pin_t;

    // FSR1 over FSR0, two select bits per pin.
    typedef logic [2*`GPIO_PINS-1:0] func_t;

    // Phase of the current APB cycle.
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

endpackage

`default_nettype wire

//--- source/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defs.svh"

module gpio_regs (
    input  logic              seq,
    input  logic              arst_n,

    input  logic              reg_wr,
    input  logic              reg_rd,
    input  gpio_pkg::addr_t   reg_addr,
    input  gpio_pkg::data_t   reg_wdata,
    input  gpio_pkg::strb_t   reg_strb,
    output gpio_pkg::data_t   reg_rdata,
    output logic              reg_err,

    input  gpio_pkg::pin_t    idr,
    output gpio_pkg::pin_t    odr,
    output gpio_pkg::pin_t    moder,
    output gpio_pkg::pin_t    otyper,
    output gpio_pkg::pin_t    ier,
    output gpio_pkg::func_t   func
);

    gpio_pkg::pin_t fsr0;
    gpio_pkg::pin_t fsr1;
    logic           writable;

    // Byte lanes beyond the register width are dropped.
    function automatic gpio_pkg::pin_t lane_write(
        input gpio_pkg::pin_t  cur,
        input gpio_pkg::data_t wdata,
        input gpio_pkg::strb_t strb
    );
        gpio_pkg::pin_t res;
        res = cur;
        for (int b = 0; b < `GPIO_PINS/8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        case (reg_addr)
            `GPIO_ODR, `GPIO_MODER, `GPIO_OTYPER,
            `GPIO_FSR0, `GPIO_FSR1, `GPIO_IER: writable = 1'b1;
            default:                           writable = 1'b0;
        endcase
    end

    // IDR is read only.
    assign reg_err = reg_wr && !writable;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            odr    <= '0;
            moder  <= '0;
            otyper <= '0;
            fsr0   <= '0;
            fsr1   <= '0;
            ier    <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                `GPIO_ODR:    odr    <= lane_write(odr, reg_wdata, reg_strb);
                `GPIO_MODER:  moder  <= lane_write(moder, reg_wdata, reg_strb);
                `GPIO_OTYPER: otyper <= lane_write(otyper, reg_wdata, reg_strb);
                `GPIO_FSR0:   fsr0   <= lane_write(fsr0, reg_wdata, reg_strb);
                `GPIO_FSR1:   fsr1   <= lane_write(fsr1, reg_wdata, reg_strb);
                `GPIO_IER:    ier    <= lane_write(ier, reg_wdata, reg_strb);
                default: ;
            endcase
        end
    end

    assign func = {fsr1, fsr0};

    // Zero extended; unmapped offsets read as zero.
    always_comb begin
        reg_rdata = '0;
        if (reg_rd) begin
            case (reg_addr)
                `GPIO_IDR:    reg_rdata[`GPIO_PINS-1:0] = idr;
                `GPIO_ODR:    reg_rdata[`GPIO_PINS-1:0] = odr;
                `GPIO_MODER:  reg_rdata[`GPIO_PINS-1:0] = moder;
                `GPIO_OTYPER: reg_rdata[`GPIO_PINS-1:0] = otyper;
                `GPIO_FSR0:   reg_rdata[`GPIO_PINS-1:0] = fsr0;
                `GPIO_FSR1:   reg_rdata[`GPIO_PINS-1:0] = fsr1;
                `GPIO_IER:    reg_rdata[`GPIO_PINS-1:0] = ier;
                default: ;
            endcase
        end
    end

    wr_rd_exclusive: assert property (
        @(posedge seq) disable iff (!arst_n) !(reg_wr && reg_rd)
    );

endmodule

`default_nettype wire

//--- source/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
    input  logic              seq,
    input  logic              arst_n,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  gpio_pkg::addr_t   paddr,
    input  gpio_pkg::data_t   pwdata,
    input  gpio_pkg::strb_t   pstrb,
    output gpio_pkg::data_t   prdata,
    output logic              pready,
    output logic              pslverr,

    input  gpio_pkg::pin_t    pad_in,
    output gpio_pkg::pin_t    pad_out,
    output gpio_pkg::pin_t    pad_oe,
    input  gpio_pkg::pin_t    alt_out,
    input  gpio_pkg::pin_t    alt_oe,
    output gpio_pkg::func_t   func,
    output logic              irq
);

    logic            reg_wr;
    logic            reg_rd;
    gpio_pkg::addr_t reg_addr;
    gpio_pkg::data_t reg_wdata;
    gpio_pkg::strb_t reg_strb;
    gpio_pkg::data_t reg_rdata;
    logic            reg_err;
    gpio_pkg::pin_t  idr;
    gpio_pkg::pin_t  odr;
    gpio_pkg::pin_t  moder;
    gpio_pkg::pin_t  otyper;
    gpio_pkg::pin_t  ier;

    gpio_apb_slave u_apb_slave (
        .seq       (seq),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_strb  (reg_strb),
        .reg_rdata (reg_rdata),
        .reg_err   (reg_err)
    );

    gpio_regs u_regs (
        .seq       (seq),
        .arst_n    (arst_n),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_strb  (reg_strb),
        .reg_rdata (reg_rdata),
        .reg_err   (reg_err),
        .idr       (idr),
        .odr       (odr),
        .moder     (moder),
        .otyper    (otyper),
        .ier       (ier),
        .func      (func)
    );

    gpio_pad_ctrl u_pad_ctrl (
        .seq     (seq),
        .arst_n  (arst_n),
        .pad_in  (pad_in),
        .pad_out (pad_out),
        .pad_oe  (pad_oe),
        .odr     (odr),
        .moder   (moder),
        .otyper  (otyper),
        .ier     (ier),
        .func    (func),
        .idr     (idr),
        .alt_out (alt_out),
        .alt_oe  (alt_oe),
        .irq     (irq)
    );

endmodule

`default_nettype wire

//--- tb/gpio_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defs.svh"

module gpio_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int ITERATIONS   = 200;
    localparam int ITER_CYCLES  = 12;
    localparam int TIMEOUT_NS   = (ITERATIONS * ITER_CYCLES + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'hc1b7dd6c;

    typedef struct packed {
        gpio_pkg::data_t rdata;
        logic            slverr;
        gpio_pkg::pin_t  pad_out;
        gpio_pkg::pin_t  pad_oe;
        gpio_pkg::func_t func;
        logic            irq;
    } result_t;

    logic            seq = 1'b0;
    logic            arst_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    gpio_pkg::addr_t paddr;
    gpio_pkg::data_t pwdata;
    gpio_pkg::strb_t pstrb;
    gpio_pkg::data_t prdata;
    logic            pready;
    logic            pslverr;
    gpio_pkg::pin_t  pad_in;
    gpio_pkg::pin_t  pad_out;
    gpio_pkg::pin_t  pad_oe;
    gpio_pkg::pin_t  alt_out;
    gpio_pkg::pin_t  alt_oe;
    gpio_pkg::func_t func;
    logic            irq;

    // Shadow copies of the writable registers.
    gpio_pkg::pin_t  sh_odr;
    gpio_pkg::pin_t  sh_moder;
    gpio_pkg::pin_t  sh_otyper;
    gpio_pkg::pin_t  sh_fsr0;
    gpio_pkg::pin_t  sh_fsr1;
    gpio_pkg::pin_t  sh_ier;

    result_t         got;
    result_t         exp;
    logic            exp_read;
    gpio_pkg::addr_t exp_addr;
    int              errors = 0;
    int              checks = 0;
    event            compare_ev;

    gpio_top uut (
        .seq     (seq),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pad_in  (pad_in),
        .pad_out (pad_out),
        .pad_oe  (pad_oe),
        .alt_out (alt_out),
        .alt_oe  (alt_oe),
        .func    (func),
        .irq     (irq)
    );

    always #(CLK_PERIOD / 2) seq = ~seq;

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    // Only byte lanes 0 and 1 exist in a 16 bit register.
    function automatic gpio_pkg::pin_t merge_lanes(
        input gpio_pkg::pin_t  cur,
        input gpio_pkg::data_t wdata,
        input gpio_pkg::strb_t strb
    );
        gpio_pkg::pin_t res;
        res = cur;
        if (strb[0]) begin
            res[7:0] = wdata[7:0];
        end
        if (strb[1]) begin
            res[15:8] = wdata[15:8];
        end
        return res;
    endfunction

    task automatic update_shadow(
        input gpio_pkg::addr_t addr,
        input gpio_pkg::data_t wdata,
        input gpio_pkg::strb_t strb
    );
        case (addr)
            `GPIO_ODR:    sh_odr    = merge_lanes(sh_odr, wdata, strb);
            `GPIO_MODER:  sh_moder  = merge_lanes(sh_moder, wdata, strb);
            `GPIO_OTYPER: sh_otyper = merge_lanes(sh_otyper, wdata, strb);
            `GPIO_FSR0:   sh_fsr0   = merge_lanes(sh_fsr0, wdata, strb);
            `GPIO_FSR1:   sh_fsr1   = merge_lanes(sh_fsr1, wdata, strb);
            `GPIO_IER:    sh_ier    = merge_lanes(sh_ier, wdata, strb);
            default: ;
        endcase
    endtask

    function automatic result_t ref_model(
        input logic            wr,
        input gpio_pkg::addr_t addr,
        input gpio_pkg::pin_t  pins,
        input gpio_pkg::pin_t  aout,
        input gpio_pkg::pin_t  aoe
    );
        result_t         r;
        gpio_pkg::func_t fsel;
        r    = '0;
        fsel = {sh_fsr1, sh_fsr0};
        if (!wr) begin
            case (addr)
                `GPIO_IDR:    r.rdata = {16'h0000, pins};
                `GPIO_ODR:    r.rdata = {16'h0000, sh_odr};
                `GPIO_MODER:  r.rdata = {16'h0000, sh_moder};
                `GPIO_OTYPER: r.rdata = {16'h0000, sh_otyper};
                `GPIO_FSR0:   r.rdata = {16'h0000, sh_fsr0};
                `GPIO_FSR1:   r.rdata = {16'h0000, sh_fsr1};
                `GPIO_IER:    r.rdata = {16'h0000, sh_ier};
                default:      r.rdata = '0;
            endcase
        end
        case (addr)
            `GPIO_ODR, `GPIO_MODER, `GPIO_OTYPER,
            `GPIO_FSR0, `GPIO_FSR1, `GPIO_IER: r.slverr = 1'b0;
            default:                           r.slverr = wr;
        endcase
        for (int i = 0; i < `GPIO_PINS; i++) begin
            if (fsel[2*i] || fsel[2*i+1]) begin
                r.pad_out[i] = aout[i];
                r.pad_oe[i]  = aoe[i];
            end else begin
                r.pad_out[i] = sh_odr[i];
                if (!sh_moder[i]) begin
                    r.pad_oe[i] = 1'b0;
                end else if (sh_otyper[i]) begin
                    r.pad_oe[i] = ~sh_odr[i];
                end else begin
                    r.pad_oe[i] = 1'b1;
                end
            end
        end
        r.func = fsel;
        r.irq  = |(sh_ier & pins);
        return r;
    endfunction

    task automatic apb_transfer(
        input  logic            wr,
        input  gpio_pkg::addr_t addr,
        input  gpio_pkg::data_t wdata,
        input  gpio_pkg::strb_t strb,
        output gpio_pkg::data_t rdata,
        output logic            slverr
    );
        @(posedge seq);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge seq);
        penable <= 1'b1;
        @(negedge seq);
        if (pready !== 1'b1) begin
            errors = errors + 1;
            $display("Mismatch pready @%h: got %h, expected 1", addr, pready);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge seq);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic run_op(
        input logic            wr,
        input gpio_pkg::addr_t addr,
        input gpio_pkg::data_t wdata,
        input gpio_pkg::strb_t strb
    );
        gpio_pkg::data_t rdata;
        logic            slverr;
        apb_transfer(wr, addr, wdata, strb, rdata, slverr);
        if (wr) begin
            update_shadow(addr, wdata, strb);
        end
        // irq follows an IER write one cycle later.
        @(posedge seq);
        @(negedge seq);
        got.rdata   = rdata;
        got.slverr  = slverr;
        got.pad_out = pad_out;
        got.pad_oe  = pad_oe;
        got.func    = func;
        got.irq     = irq;
        exp         = ref_model(wr, addr, pad_in, alt_out, alt_oe);
        exp_read    = !wr;
        exp_addr    = addr;
        -> compare_ev;
    endtask

    always @(compare_ev) begin
        checks = checks + 1;
        if (exp_read && got.rdata !== exp.rdata) begin
            errors = errors + 1;
            $display("Mismatch prdata @%h: got %h, expected %h", exp_addr, got.rdata, exp.rdata);
        end
        if (got.slverr !== exp.slverr) begin
            errors = errors + 1;
            $display("Mismatch pslverr @%h: got %h, expected %h",
                     exp_addr, got.slverr, exp.slverr);
        end
        if (got.pad_out !== exp.pad_out) begin
            errors = errors + 1;
            $display("Mismatch pad_out: got %h, expected %h", got.pad_out, exp.pad_out);
        end
        if (got.pad_oe !== exp.pad_oe) begin
            errors = errors + 1;
            $display("Mismatch pad_oe: got %h, expected %h", got.pad_oe, exp.pad_oe);
        end
        if (got.func !== exp.func) begin
            errors = errors + 1;
            $display("Mismatch func: got %h, expected %h", got.func, exp.func);
        end
        if (got.irq !== exp.irq) begin
            errors = errors + 1;
            $display("Mismatch irq: got %h, expected %h", got.irq, exp.irq);
        end
    end

    initial begin
        logic [31:0]     rnd;
        logic            wr;
        gpio_pkg::addr_t addr;
        gpio_pkg::data_t wdata;
        gpio_pkg::strb_t strb;
        rnd       = $urandom(SEED);
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        pad_in    = '0;
        alt_out   = '0;
        alt_oe    = '0;
        sh_odr    = '0;
        sh_moder  = '0;
        sh_otyper = '0;
        sh_fsr0   = '0;
        sh_fsr1   = '0;
        sh_ier    = '0;
        repeat (RESET_CYCLES) @(posedge seq);
        arst_n <= 1'b1;
        @(negedge seq);

        if (pready !== 1'b0) begin
            errors = errors + 1;
            $display("Mismatch pready after reset: got %h, expected 0", pready);
        end
        if (pslverr !== 1'b0) begin
            errors = errors + 1;
            $display("Mismatch pslverr after reset: got %h, expected 0", pslverr);
        end

        // Every register reads zero out of reset.
        addr = '0;
        while (addr <= `GPIO_IER) begin
            run_op(1'b0, addr, '0, '0);
            addr = addr + 12'h004;
        end

        for (int n = 0; n < ITERATIONS; n++) begin
            @(posedge seq);
            rnd      = $urandom;
            pad_in  <= rnd[15:0];
            alt_out <= rnd[31:16];
            rnd      = $urandom;
            alt_oe  <= rnd[15:0];
            wr       = rnd[16];
            strb     = rnd[20:17];
            addr     = {7'b0000000, rnd[23:21], 2'b00};
            wdata    = $urandom;
            repeat (3) @(posedge seq);
            run_op(wr, addr, wdata, strb);
        end

        @(posedge seq);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
